// File: Makefile
VERILATOR ?= verilator
TOP       ?= dbg_bridge_tb
FILELIST  ?= dbg_bridge_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dbg_bridge_top.f
hw/dbg_bus_pkg.sv
hw/dbg_ctl_pkg.sv
hw/dbg_apb_target.sv
hw/dbg_reg_bank.sv
hw/dbg_fanout.sv
hw/dbg_bridge_top.sv
tb/dbg_bridge_chk.sv
tb/dbg_bridge_tb.sv

// File: hw/dbg_apb_target.sv
`default_nettype none

module dbg_apb_target
	import dbg_bus_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     arst_n_i,
	input  wire apb_req_t apb_req_i,
	output apb_rsp_t      apb_rsp_o,
	output reg_req_t      reg_req_o,
	input  wire reg_rsp_t reg_rsp_i
);

	apb_phase_e phase_q;
	apb_phase_e cur_phase;
	dbg_op_e    op;
	logic       access;

	// Phase of the current cycle, ACCESS only directly after SETUP
	always_comb begin
		if (!apb_req_i.psel) begin
			cur_phase = PH_IDLE;
		end else if (!apb_req_i.penable) begin
			cur_phase = PH_SETUP;
		end else if (phase_q == PH_SETUP) begin
			cur_phase = PH_ACCESS;
		end else begin
			// Enable without a preceding setup is ignored
			cur_phase = PH_IDLE;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			phase_q <= PH_IDLE;
		end else begin
			phase_q <= cur_phase;
		end
	end

	assign access = (cur_phase == PH_ACCESS);

	always_comb begin
		if (!access) begin
			op = OP_NONE;
		end else if (apb_req_i.pwrite) begin
			op = OP_WRITE;
		end else begin
			op = OP_READ;
		end
	end

	// One request per ACCESS cycle
	assign reg_req_o.op    = op;
	assign reg_req_o.addr  = apb_req_i.paddr;
	assign reg_req_o.wdata = apb_req_i.pwdata;

	// No wait states, the bank answers in the same cycle
	assign apb_rsp_o.pready  = access;
	assign apb_rsp_o.pslverr = access & reg_rsp_i.err;
	assign apb_rsp_o.prdata  = access ? reg_rsp_i.rdata : '0;

endmodule

`default_nettype wire

// File: hw/dbg_bridge_top.sv
`default_nettype none

module dbg_bridge_top
	import dbg_bus_pkg::*;
	import dbg_ctl_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      arst_n_i,
	input  wire apb_req_t  apb_req_i,
	output apb_rsp_t       apb_rsp_o,
	input  wire cdr_sts_t  cdr_sts_i,
	input  wire prbs_sts_t prbs_sts_i,
	output ana_ctl_t       ana_ctl_o,
	output cdr_ctl_t       cdr_ctl_o,
	output prbs_ctl_t      prbs_ctl_o,
	output blk_rst_t       blk_rst_o
);

	reg_req_t    reg_req;
	reg_rsp_t    reg_rsp;
	active_cfg_t active_cfg;
	blk_rst_t    rst_ctl;

	// Host port
	dbg_apb_target i_dbg_apb_target (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.apb_req_i (apb_req_i),
		.apb_rsp_o (apb_rsp_o),
		.reg_req_o (reg_req),
		.reg_rsp_i (reg_rsp)
	);

	dbg_reg_bank i_dbg_reg_bank (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.reg_req_i    (reg_req),
		.reg_rsp_o    (reg_rsp),
		.cdr_sts_i    (cdr_sts_i),
		.prbs_sts_i   (prbs_sts_i),
		.active_cfg_o (active_cfg),
		.rst_ctl_o    (rst_ctl)
	);

	// Controls and resets toward front end, CDR and PRBS
	dbg_fanout i_dbg_fanout (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.active_cfg_i (active_cfg),
		.rst_ctl_i    (rst_ctl),
		.ana_ctl_o    (ana_ctl_o),
		.cdr_ctl_o    (cdr_ctl_o),
		.prbs_ctl_o   (prbs_ctl_o),
		.blk_rst_o    (blk_rst_o)
	);

endmodule

`default_nettype wire

// File: hw/dbg_bus_pkg.sv
`default_nettype none

package dbg_bus_pkg;

	localparam int DBG_ADDR_W = 8;
	localparam int DBG_DATA_W = 32;

	// Register map, byte addresses
	localparam logic [DBG_ADDR_W-1:0] ADDR_ID       = 8'h00;
	localparam logic [DBG_ADDR_W-1:0] ADDR_RST      = 8'h04;
	localparam logic [DBG_ADDR_W-1:0] ADDR_ANA      = 8'h08;
	localparam logic [DBG_ADDR_W-1:0] ADDR_CDR_GAIN = 8'h0C;
	localparam logic [DBG_ADDR_W-1:0] ADDR_CDR_EXT  = 8'h10;
	localparam logic [DBG_ADDR_W-1:0] ADDR_PRBS     = 8'h14;
	localparam logic [DBG_ADDR_W-1:0] ADDR_COMMIT   = 8'h18;
	localparam logic [DBG_ADDR_W-1:0] ADDR_PHASE    = 8'h20;
	localparam logic [DBG_ADDR_W-1:0] ADDR_PRBS_ERR = 8'h24;

	localparam logic [DBG_DATA_W-1:0] ID_VALUE = 32'h5EA1_0001;

	// COMMIT register bits
	localparam int COMMIT_UPDATE_BIT  = 0;
	localparam int COMMIT_CAPTURE_BIT = 1;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE
	} dbg_op_e;

	typedef enum logic [1:0] {
		PH_IDLE,
		PH_SETUP,
		PH_ACCESS
	} apb_phase_e;

	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [DBG_ADDR_W-1:0] paddr;
		logic [DBG_DATA_W-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic                  pready;
		logic                  pslverr;
		logic [DBG_DATA_W-1:0] prdata;
	} apb_rsp_t;

	typedef struct packed {
		dbg_op_e               op;
		logic [DBG_ADDR_W-1:0] addr;
		logic [DBG_DATA_W-1:0] wdata;
	} reg_req_t;

	typedef struct packed {
		logic [DBG_DATA_W-1:0] rdata;
		logic                  err;
	} reg_rsp_t;

endpackage

`default_nettype wire

// File: hw/dbg_ctl_pkg.sv
`default_nettype none

package dbg_ctl_pkg;

	// Analog front end field widths
	localparam int DCDL_W      = 8;
	localparam int INBUF_DIV_W = 3;

	// CDR loop field widths
	localparam int KP_W     = 4;
	localparam int KI_W     = 4;
	localparam int PI_CTL_W = 9;
	localparam int PHASE_W  = 16;

	// PRBS checker field widths
	localparam int PRBS_MODE_W = 2;
	localparam int PRBS_INIT_W = 16;
	localparam int ERR_CNT_W   = 32;

	// Block reset distribution
	localparam int NUM_BLK_RST = 3;
	localparam int SYNC_STAGES = 2;

	// Fields listed MSB first so each struct lines up with its register
	typedef struct packed {
		logic [INBUF_DIV_W-1:0] inbuf_ndiv;
		logic                   en_biasgen;
		logic [DCDL_W-1:0]      dcdl_code;
	} ana_ctl_t;

	typedef struct packed {
		logic                en_ext_pi_ctl;
		logic [PI_CTL_W-1:0] ext_pi_ctl;
		logic [KI_W-1:0]     ki;
		logic [KP_W-1:0]     kp;
	} cdr_ctl_t;

	typedef struct packed {
		logic [PRBS_INIT_W-1:0] init_val;
		logic [PRBS_MODE_W-1:0] mode;
	} prbs_ctl_t;

	typedef struct packed {
		logic [PHASE_W-1:0] phase_est;
	} cdr_sts_t;

	typedef struct packed {
		logic [ERR_CNT_W-1:0] err_cnt;
	} prbs_sts_t;

	// All active low, int_rstb in bit 0
	typedef struct packed {
		logic prbs_rstb;
		logic cdr_rstb;
		logic int_rstb;
	} blk_rst_t;

	typedef struct packed {
		ana_ctl_t  ana;
		cdr_ctl_t  cdr;
		prbs_ctl_t prbs;
	} active_cfg_t;

	localparam blk_rst_t RST_DEFAULT = 3'b111;

endpackage

`default_nettype wire

// File: hw/dbg_fanout.sv
`default_nettype none

module dbg_fanout
	import dbg_ctl_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        arst_n_i,
	input  wire active_cfg_t active_cfg_i,
	input  wire blk_rst_t    rst_ctl_i,
	output ana_ctl_t         ana_ctl_o,
	output cdr_ctl_t         cdr_ctl_o,
	output prbs_ctl_t        prbs_ctl_o,
	output blk_rst_t         blk_rst_o
);

	blk_rst_t               gated_rst;
	logic [NUM_BLK_RST-1:0] raw_rstb;
	logic [NUM_BLK_RST-1:0] sync_rstb;

	// Per-block controls
	assign ana_ctl_o  = active_cfg_i.ana;
	assign cdr_ctl_o  = active_cfg_i.cdr;
	assign prbs_ctl_o = active_cfg_i.prbs;

	// Internal reset also holds the CDR and PRBS blocks
	assign gated_rst.int_rstb  = rst_ctl_i.int_rstb;
	assign gated_rst.cdr_rstb  = rst_ctl_i.int_rstb & rst_ctl_i.cdr_rstb;
	assign gated_rst.prbs_rstb = rst_ctl_i.int_rstb & rst_ctl_i.prbs_rstb;

	assign raw_rstb = gated_rst;

	// Assert asynchronously, release through a two-flop synchronizer
	for (genvar i = 0; i < NUM_BLK_RST; i++) begin : g_rst_sync
		logic                   blk_arst_n;
		logic [SYNC_STAGES-1:0] sync_q;

		assign blk_arst_n = arst_n_i & raw_rstb[i];

		always_ff @(posedge clk or negedge blk_arst_n) begin
			if (!blk_arst_n) begin
				sync_q <= '0;
			end else begin
				sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};
			end
		end

		assign sync_rstb[i] = sync_q[SYNC_STAGES-1];
	end

	assign blk_rst_o = sync_rstb;

endmodule

`default_nettype wire

// File: hw/dbg_reg_bank.sv
`default_nettype none

module dbg_reg_bank
	import dbg_bus_pkg::*;
	import dbg_ctl_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      arst_n_i,
	input  wire reg_req_t  reg_req_i,
	output reg_rsp_t       reg_rsp_o,
	input  wire cdr_sts_t  cdr_sts_i,
	input  wire prbs_sts_t prbs_sts_i,
	output active_cfg_t    active_cfg_o,
	output blk_rst_t       rst_ctl_o
);

	active_cfg_t           shadow_q;
	active_cfg_t           active_q;
	blk_rst_t              rst_q;
	cdr_sts_t              cdr_cap_q;
	prbs_sts_t             prbs_cap_q;
	logic                  rd_en;
	logic                  wr_en;
	logic                  rd_ok;
	logic                  wr_ok;
	logic                  wr_go;
	logic [DBG_DATA_W-1:0] rdata;

	assign rd_en = (reg_req_i.op == OP_READ);
	assign wr_en = (reg_req_i.op == OP_WRITE);
	assign wr_go = wr_en & wr_ok;

	// Address decode and read data
	always_comb begin
		rdata = '0;
		rd_ok = 1'b1;
		wr_ok = 1'b1;
		case (reg_req_i.addr)
			ADDR_ID: begin
				rdata = ID_VALUE;
				wr_ok = 1'b0;
			end
			ADDR_RST: begin
				rdata[NUM_BLK_RST-1:0] = rst_q;
			end
			ADDR_ANA: begin
				rdata[$bits(ana_ctl_t)-1:0] = shadow_q.ana;
			end
			ADDR_CDR_GAIN: begin
				rdata[3:0] = shadow_q.cdr.kp;
				rdata[7:4] = shadow_q.cdr.ki;
			end
			ADDR_CDR_EXT: begin
				rdata[8:0] = shadow_q.cdr.ext_pi_ctl;
				rdata[16]  = shadow_q.cdr.en_ext_pi_ctl;
			end
			ADDR_PRBS: begin
				rdata[1:0]   = shadow_q.prbs.mode;
				rdata[31:16] = shadow_q.prbs.init_val;
			end
			ADDR_COMMIT: begin
				// Write-only strobes, reads return zero
				rdata = '0;
			end
			ADDR_PHASE: begin
				rdata[PHASE_W-1:0] = cdr_cap_q.phase_est;
				wr_ok = 1'b0;
			end
			ADDR_PRBS_ERR: begin
				rdata = prbs_cap_q.err_cnt;
				wr_ok = 1'b0;
			end
			default: begin
				rd_ok = 1'b0;
				wr_ok = 1'b0;
			end
		endcase
	end

	assign reg_rsp_o.rdata = rd_en ? rdata : '0;
	assign reg_rsp_o.err   = (rd_en & ~rd_ok) | (wr_en & ~wr_ok);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			shadow_q   <= '0;
			active_q   <= '0;
			rst_q      <= RST_DEFAULT;
			cdr_cap_q  <= '0;
			prbs_cap_q <= '0;
		end else if (wr_go) begin
			case (reg_req_i.addr)
				ADDR_RST: begin
					rst_q <= reg_req_i.wdata[NUM_BLK_RST-1:0];
				end
				ADDR_ANA: begin
					shadow_q.ana <= reg_req_i.wdata[$bits(ana_ctl_t)-1:0];
				end
				ADDR_CDR_GAIN: begin
					shadow_q.cdr.kp <= reg_req_i.wdata[3:0];
					shadow_q.cdr.ki <= reg_req_i.wdata[7:4];
				end
				ADDR_CDR_EXT: begin
					shadow_q.cdr.ext_pi_ctl    <= reg_req_i.wdata[8:0];
					shadow_q.cdr.en_ext_pi_ctl <= reg_req_i.wdata[16];
				end
				ADDR_PRBS: begin
					shadow_q.prbs.mode     <= reg_req_i.wdata[1:0];
					shadow_q.prbs.init_val <= reg_req_i.wdata[31:16];
				end
				ADDR_COMMIT: begin
					if (reg_req_i.wdata[COMMIT_UPDATE_BIT]) begin
						active_q <= shadow_q;
					end
					// Snapshot of block status at the commit edge
					if (reg_req_i.wdata[COMMIT_CAPTURE_BIT]) begin
						cdr_cap_q  <= cdr_sts_i;
						prbs_cap_q <= prbs_sts_i;
					end
				end
				default: begin
				end
			endcase
		end
	end

	assign active_cfg_o = active_q;
	assign rst_ctl_o    = rst_q;

endmodule

`default_nettype wire

// File: tb/dbg_bridge_chk.sv
`default_nettype none

module dbg_bridge_chk
	import dbg_bus_pkg::*;
	import dbg_ctl_pkg::*;
#(
	parameter bit APB_SIDE = 1'b1
) (
	input wire logic     clk,
	input wire logic     arst_n_i,
	input wire apb_req_t apb_req_i,
	input wire apb_rsp_t apb_rsp_i,
	input wire blk_rst_t blk_rst_i
);

	if (APB_SIDE) begin : g_apb
		// Only an ACCESS right after SETUP completes a transfer
		assert property (@(posedge clk) disable iff (!arst_n_i)
			apb_rsp_i.pready |-> apb_req_i.psel && apb_req_i.penable
				&& $past(apb_req_i.psel && !apb_req_i.penable))
		else $error("pready high outside an ACCESS cycle");

		assert property (@(posedge clk) disable iff (!arst_n_i)
			apb_req_i.psel && apb_req_i.penable
				&& $past(apb_req_i.psel && !apb_req_i.penable)
			|-> $stable(apb_req_i.paddr))
		else $error("paddr changed between SETUP and ACCESS");

		assert property (@(posedge clk) disable iff (!arst_n_i)
			apb_rsp_i.pslverr |-> apb_rsp_i.pready)
		else $error("pslverr high without pready");
	end else begin : g_rst
		// Internal reset holds the CDR and PRBS blocks as well
		assert property (@(posedge clk) disable iff (!arst_n_i)
			!blk_rst_i.int_rstb |-> !blk_rst_i.cdr_rstb && !blk_rst_i.prbs_rstb)
		else $error("block reset released while int reset is asserted");
	end

endmodule

bind dbg_apb_target dbg_bridge_chk #(.APB_SIDE(1'b1)) i_apb_chk (
	.clk       (clk),
	.arst_n_i  (arst_n_i),
	.apb_req_i (apb_req_i),
	.apb_rsp_i (apb_rsp_o),
	.blk_rst_i (3'b111)
);

bind dbg_fanout dbg_bridge_chk #(.APB_SIDE(1'b0)) i_rst_chk (
	.clk       (clk),
	.arst_n_i  (arst_n_i),
	.apb_req_i ('0),
	.apb_rsp_i ('0),
	.blk_rst_i (blk_rst_o)
);

`default_nettype wire

// File: tb/dbg_bridge_tb.sv
`default_nettype none

module dbg_bridge_tb
	import dbg_bus_pkg::*;
	import dbg_ctl_pkg::*;
();

	localparam int PERIOD     = 8;
	localparam int RST_CYCLES = 16;
	localparam int N_SHADOW   = 40;
	localparam int N_CAPTURE  = 10;
	localparam int N_ILLEGAL  = 30;
	localparam int N_RST      = 20;
	// Three sweeps of 10 reads, idle waits of the reset test counted as a transfer
	localparam int N_XFERS = 30 + 3 * N_SHADOW + 3 * N_CAPTURE + 2 * N_ILLEGAL + 3 * N_RST;
	localparam int WATCHDOG_CYCLES = RST_CYCLES + 4 * N_XFERS + 200;

	logic      clk;
	logic      arst_n;
	apb_req_t  apb_req;
	apb_rsp_t  apb_rsp;
	cdr_sts_t  cdr_sts;
	prbs_sts_t prbs_sts;
	ana_ctl_t  ana_ctl;
	cdr_ctl_t  cdr_ctl;
	prbs_ctl_t prbs_ctl;
	blk_rst_t  blk_rst;

	int seed   = 4128;
	int checks = 0;
	int errors = 0;

	// Model indexed by word address, 0x1C unused
	logic [DBG_DATA_W-1:0] regs_m [10];
	logic [DBG_DATA_W-1:0] active_m [10];

	dbg_bridge_top i_dbg_bridge_top (
		.clk        (clk),
		.arst_n_i   (arst_n),
		.apb_req_i  (apb_req),
		.apb_rsp_o  (apb_rsp),
		.cdr_sts_i  (cdr_sts),
		.prbs_sts_i (prbs_sts),
		.ana_ctl_o  (ana_ctl),
		.cdr_ctl_o  (cdr_ctl),
		.prbs_ctl_o (prbs_ctl),
		.blk_rst_o  (blk_rst)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Timeout: test did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic check_rdata(input string name, input logic [DBG_DATA_W-1:0] exp,
			input logic [DBG_DATA_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_err(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_ana(input string name, input ana_ctl_t exp, input ana_ctl_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_cdr(input string name, input cdr_ctl_t exp, input cdr_ctl_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_prbs(input string name, input prbs_ctl_t exp, input prbs_ctl_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_rst(input string name, input blk_rst_t exp, input blk_rst_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic mapped(input logic [DBG_ADDR_W-1:0] addr);
		return addr inside {ADDR_ID, ADDR_RST, ADDR_ANA, ADDR_CDR_GAIN, ADDR_CDR_EXT,
			ADDR_PRBS, ADDR_COMMIT, ADDR_PHASE, ADDR_PRBS_ERR};
	endfunction

	function automatic logic writable(input logic [DBG_ADDR_W-1:0] addr);
		return mapped(addr) && !(addr inside {ADDR_ID, ADDR_PHASE, ADDR_PRBS_ERR});
	endfunction

	// Int reset also holds CDR and PRBS
	function automatic blk_rst_t gated_rst(input logic [DBG_DATA_W-1:0] rst_reg);
		return {rst_reg[0] & rst_reg[2], rst_reg[0] & rst_reg[1], rst_reg[0]};
	endfunction

	task automatic new_status();
		logic [31:0] r;
		r = rand32();
		cdr_sts  = r[15:0];
		prbs_sts = rand32();
	endtask

	// SETUP then ACCESS, response sampled mid ACCESS
	task automatic apb_transfer(input logic write, input logic [DBG_ADDR_W-1:0] addr,
			input logic [DBG_DATA_W-1:0] wdata, output logic [DBG_DATA_W-1:0] rdata,
			output logic err);
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge clk);
		#1 apb_req.penable = 1'b1;
		@(negedge clk);
		check_err("pready in ACCESS", 1'b1, apb_rsp.pready);
		rdata = apb_rsp.prdata;
		err   = apb_rsp.pslverr;
		@(posedge clk);
		#1 apb_req = '0;
	endtask

	task automatic model_write(input logic [DBG_ADDR_W-1:0] addr,
			input logic [DBG_DATA_W-1:0] data);
		case (addr)
			ADDR_RST:      regs_m[1] = data & 32'h0000_0007;
			ADDR_ANA:      regs_m[2] = data & 32'h0000_0FFF;
			ADDR_CDR_GAIN: regs_m[3] = data & 32'h0000_00FF;
			ADDR_CDR_EXT:  regs_m[4] = data & 32'h0001_01FF;
			ADDR_PRBS:     regs_m[5] = data & 32'hFFFF_0003;
			ADDR_COMMIT: begin
				if (data[0]) begin
					active_m = regs_m;
				end
				if (data[1]) begin
					regs_m[8] = {16'h0000, cdr_sts.phase_est};
					regs_m[9] = prbs_sts.err_cnt;
				end
			end
			default: begin
			end
		endcase
	endtask

	task automatic write_reg(input logic [DBG_ADDR_W-1:0] addr,
			input logic [DBG_DATA_W-1:0] data);
		logic [DBG_DATA_W-1:0] rdata;
		logic                  err;
		apb_transfer(1'b1, addr, data, rdata, err);
		check_err($sformatf("write %h slverr", addr), !writable(addr), err);
		if (writable(addr)) begin
			model_write(addr, data);
		end
	endtask

	task automatic read_reg(input logic [DBG_ADDR_W-1:0] addr);
		logic [DBG_DATA_W-1:0] rdata;
		logic                  err;
		apb_transfer(1'b0, addr, '0, rdata, err);
		check_err($sformatf("read %h slverr", addr), !mapped(addr), err);
		if (mapped(addr)) begin
			check_rdata($sformatf("read %h", addr), regs_m[addr[5:2]], rdata);
		end
	endtask

	task automatic read_all();
		for (int a = 0; a <= 'h24; a += 4) begin
			read_reg(8'(a));
		end
	endtask

	// Expected controls rebuilt from the committed register fields
	task automatic check_outputs(input string name);
		check_ana(name, active_m[2][11:0], ana_ctl);
		check_cdr(name, {active_m[4][16], active_m[4][8:0], active_m[3][7:0]}, cdr_ctl);
		check_prbs(name, {active_m[5][31:16], active_m[5][1:0]}, prbs_ctl);
	endtask

	initial begin
		logic [31:0]           r;
		logic [DBG_ADDR_W-1:0] addr;
		blk_rst_t              prev_rst;
		blk_rst_t              next_rst;

		apb_req  = '0;
		cdr_sts  = '0;
		prbs_sts = '0;
		arst_n   = 1'b0;
		foreach (regs_m[i]) begin
			regs_m[i] = '0;
		end
		regs_m[0] = ID_VALUE;
		regs_m[1] = 32'h0000_0007;
		active_m  = regs_m;

		repeat (RST_CYCLES) @(posedge clk);
		check_err("pready in reset", 1'b0, apb_rsp.pready);
		check_err("pslverr in reset", 1'b0, apb_rsp.pslverr);
		check_rdata("prdata in reset", '0, apb_rsp.prdata);
		#1 arst_n = 1'b1;

		// Reset state and synchronizer release
		check_rst("blk_rst at release", 3'b000, blk_rst);
		check_outputs("controls after reset");
		@(posedge clk);
		#1;
		check_rst("blk_rst one edge", 3'b000, blk_rst);
		@(posedge clk);
		#1;
		check_rst("blk_rst two edges", 3'b111, blk_rst);
		read_all();

		// Shadow writes and commit with update
		for (int i = 0; i < N_SHADOW; i++) begin
			r = rand32();
			addr = ADDR_ANA + {4'b0000, r[1:0], 2'b00};
			write_reg(addr, rand32());
			read_reg(addr);
			check_outputs("controls before commit");
			if (r[3:2] == 2'b00) begin
				write_reg(ADDR_COMMIT, {30'b0, r[4], 1'b1});
				check_outputs("controls after commit");
			end
			new_status();
		end
		read_all();

		// Status capture
		for (int i = 0; i < N_CAPTURE; i++) begin
			new_status();
			r = rand32();
			write_reg(ADDR_COMMIT, {30'b0, 1'b1, r[0]});
			new_status();
			read_reg(ADDR_PHASE);
			read_reg(ADDR_PRBS_ERR);
			check_outputs("controls after capture");
		end

		// Illegal writes and unmapped reads
		for (int i = 0; i < N_ILLEGAL; i++) begin
			r = rand32();
			addr = r[15:8];
			if (writable(addr)) begin
				case (r[1:0])
					2'b00:   addr = ADDR_ID;
					2'b01:   addr = ADDR_PHASE;
					default: addr = ADDR_PRBS_ERR;
				endcase
			end
			write_reg(addr, rand32());
			addr = r[23:16];
			if (mapped(addr)) begin
				addr = addr | 8'h01;
			end
			read_reg(addr);
		end
		read_all();
		check_outputs("controls after illegal access");

		// Block resets
		for (int i = 0; i < N_RST; i++) begin
			prev_rst = gated_rst(regs_m[1]);
			write_reg(ADDR_RST, rand32());
			next_rst = gated_rst(regs_m[1]);
			check_rst("blk_rst after write", prev_rst & next_rst, blk_rst);
			@(posedge clk);
			#1;
			check_rst("blk_rst syncing", prev_rst & next_rst, blk_rst);
			@(posedge clk);
			#1;
			check_rst("blk_rst settled", next_rst, blk_rst);
			read_reg(ADDR_RST);
		end

		$display("Result: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
